//--- Bender.yml
package:
  name: hps_io

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - hps_io_pkg.sv
      - word_loader.sv
      - uio_decoder.sv
      - ps2_key_decoder.sv
      - file_loader.sv
      - hps_io.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_hps_io.sv

//--- file_loader.sv
`timescale 1ns/100ps
`include "hps_io_cfg.svh"

module file_loader
	import hps_io_pkg::*;
(
	input  logic       clk_sys,
	input  logic       rst_n,
	input  logic       io_strobe,
	input  logic       fp_enable,
	input  io_word_t   io_din,
	output logic       ioctl_download,
	output io_word_t   ioctl_index,
	output logic       ioctl_wr,
	output file_addr_t ioctl_addr,
	output logic [7:0] ioctl_dout,
	output file_ext_t  ioctl_file_ext
);

io_word_t   cmd;
logic       has_cmd;
logic [1:0] cnt;
file_addr_t addr;
logic       wr;

always_ff @(posedge clk_sys or negedge rst_n) begin
	if (!rst_n) begin
		cmd            <= '0;
		has_cmd        <= 1'b0;
		cnt            <= '0;
		addr           <= '0;
		wr             <= 1'b0;
		ioctl_wr       <= 1'b0;
		ioctl_download <= 1'b0;
		ioctl_index    <= '0;
		ioctl_addr     <= '0;
		ioctl_dout     <= '0;
		ioctl_file_ext <= '0;
	end else begin
		// write strobe trails addr and data by one cycle
		wr       <= 1'b0;
		ioctl_wr <= wr;
		if (!fp_enable) begin
			has_cmd <= 1'b0;
		end else if (io_strobe) begin
			if (!has_cmd) begin
				cmd     <= io_din;
				has_cmd <= 1'b1;
				cnt     <= '0;
			end else begin
				if (!(&cnt))
					cnt <= cnt + 1'b1;
				case (cmd)
					`FIO_FILE_TX: begin
						case (cnt)
							2'd0: begin
								if (io_din[7:0] == 8'h00) begin
									if (ioctl_download)
										ioctl_addr <= addr;
									ioctl_download <= 1'b0;
								end else if (io_din[7:0] != `FIO_UPLOAD_MARK) begin
									addr           <= '0;
									ioctl_download <= 1'b1;
								end
							end
							2'd1: begin
								ioctl_addr[15:0] <= io_din;
								addr[15:0]       <= io_din;
							end
							2'd2: begin
								ioctl_addr[26:16] <= io_din[10:0];
								addr[26:16]       <= io_din[10:0];
							end
							default: ;
						endcase
					end
					`FIO_FILE_TX_DAT: begin
						if (ioctl_download) begin
							ioctl_addr <= addr;
							ioctl_dout <= io_din[7:0];
							wr         <= 1'b1;
							addr       <= addr + 1'b1;
						end
					end
					`FIO_FILE_INDEX: ioctl_index <= io_din;
					`FIO_FILE_INFO: begin
						// extension arrives high word first
						case (cnt)
							2'd0: ioctl_file_ext[31:16] <= io_din;
							2'd1: ioctl_file_ext[15:0]  <= io_din;
							default: ;
						endcase
					end
					default: ;
				endcase
			end
		end
	end
end

// a stop word never overtakes the write of the last data word
assert property (@(posedge clk_sys) disable iff (!rst_n) ioctl_wr |-> ioctl_download)
	else $error("file_loader: ioctl_wr outside a download");

endmodule

//--- hps_io.f
+incdir+.
hps_io_pkg.sv
word_loader.sv
uio_decoder.sv
ps2_key_decoder.sv
file_loader.sv
hps_io.sv
tb_hps_io.sv

//--- hps_io.sv
`timescale 1ns/100ps

module hps_io
	import hps_io_pkg::*;
(
	input  logic       clk_sys,
	input  logic       rst_n,

	// host word bus
	input  logic       io_strobe,
	input  logic       io_enable,
	input  logic       fp_enable,
	input  io_word_t   io_din,
	output io_word_t   io_dout,

	// user channel
	output logic [1:0] buttons,
	output logic       forced_scandoubler,
	output logic       direct_video,
	output status_t    status,
	input  status_t    status_in,
	input  logic       status_set,
	input  io_word_t   status_menumask,
	output joy_t       joystick_0,
	output joy_t       joystick_1,
	output ps2_key_t   ps2_key,

	// file download
	output logic       ioctl_download,
	output io_word_t   ioctl_index,
	output logic       ioctl_wr,
	output file_addr_t ioctl_addr,
	output logic [7:0] ioctl_dout,
	output file_ext_t  ioctl_file_ext
);

logic     kbd_start;
logic     kbd_valid;
logic     kbd_end;
io_word_t kbd_word;

uio_decoder uio_i (
	.clk_sys            (clk_sys),
	.rst_n              (rst_n),
	.io_strobe          (io_strobe),
	.io_enable          (io_enable),
	.io_din             (io_din),
	.io_dout            (io_dout),
	.status_in          (status_in),
	.status_set         (status_set),
	.status_menumask    (status_menumask),
	.buttons            (buttons),
	.forced_scandoubler (forced_scandoubler),
	.direct_video       (direct_video),
	.status             (status),
	.joystick_0         (joystick_0),
	.joystick_1         (joystick_1),
	.kbd_start          (kbd_start),
	.kbd_valid          (kbd_valid),
	.kbd_end            (kbd_end),
	.kbd_word           (kbd_word)
);

ps2_key_decoder kbd_i (
	.clk_sys   (clk_sys),
	.rst_n     (rst_n),
	.kbd_start (kbd_start),
	.kbd_valid (kbd_valid),
	.kbd_end   (kbd_end),
	.kbd_word  (kbd_word),
	.ps2_key   (ps2_key)
);

file_loader fio_i (
	.clk_sys        (clk_sys),
	.rst_n          (rst_n),
	.io_strobe      (io_strobe),
	.fp_enable      (fp_enable),
	.io_din         (io_din),
	.ioctl_download (ioctl_download),
	.ioctl_index    (ioctl_index),
	.ioctl_wr       (ioctl_wr),
	.ioctl_addr     (ioctl_addr),
	.ioctl_dout     (ioctl_dout),
	.ioctl_file_ext (ioctl_file_ext)
);

// both channels share io_din, so one frame type at a time
assert property (@(posedge clk_sys) disable iff (!rst_n) !(io_enable && fp_enable))
	else $error("hps_io: io_enable and fp_enable high together");

endmodule

//--- hps_io_cfg.svh
`ifndef HPS_IO_CFG_SVH
`define HPS_IO_CFG_SVH

////////////////////////////////////////////////////////////////////////////
// user command codes, word 0 of an io_enable frame
////////////////////////////////////////////////////////////////////////////
`define HPS_CMD_CFG         16'h0001
`define HPS_CMD_JOY0        16'h0002
`define HPS_CMD_JOY1        16'h0003
`define HPS_CMD_KBD         16'h0005
`define HPS_CMD_STATUS      16'h001E
`define HPS_CMD_STATUS_REQ  16'h0029
`define HPS_CMD_MENUMASK    16'h002E

// file command codes, word 0 of an fp_enable frame
`define FIO_FILE_TX         16'h0053
`define FIO_FILE_TX_DAT     16'h0054
`define FIO_FILE_INDEX      16'h0055
`define FIO_FILE_INFO       16'h0056
`define FIO_UPLOAD_MARK     8'hAA

// frame word counter and status reply layout
`define HPS_FRAME_CNT_W     10
`define HPS_STATUS_WORDS    8
`define HPS_STATUS_REQ_TAG  4'hA

// raw scancode sequences that get a fixed key code
`define KBD_PRNSCR_DN       32'hE012E07C
`define KBD_PRNSCR_DN_KEY   10'h37C
`define KBD_PRNSCR_UP       32'h7CE0F012
`define KBD_PRNSCR_UP_KEY   10'h17C
`define KBD_PAUSE_DN        32'hF014F077
`define KBD_PAUSE_DN_KEY    10'h377

`endif

//--- hps_io_pkg.sv
`include "hps_io_cfg.svh"

package hps_io_pkg;

	// one host bus word
	typedef logic [15:0] io_word_t;

	// core-facing payloads, all multiples of a host word
	typedef logic [31:0]  joy_t;
	typedef logic [127:0] status_t;
	typedef logic [31:0]  file_ext_t;

	// alternative key output, toggle flips on every event
	typedef struct packed {
		logic       toggle;
		logic       pressed;
		logic       extended;
		logic [7:0] code;
	} ps2_key_t;

	typedef logic [26:0] file_addr_t;
	typedef logic [`HPS_FRAME_CNT_W-1:0] frame_cnt_t;

endpackage

//--- ps2_key_decoder.sv
`timescale 1ns/100ps
`include "hps_io_cfg.svh"

module ps2_key_decoder
	import hps_io_pkg::*;
(
	input  logic     clk_sys,
	input  logic     rst_n,
	input  logic     kbd_start,
	input  logic     kbd_valid,
	input  logic     kbd_end,
	input  io_word_t kbd_word,
	output ps2_key_t ps2_key
);

logic [31:0] raw;
logic        skip;
logic        pressed;
logic        extended;
ps2_key_t    key_next;

// F0 marks a release, E0 sits before the release marker or the code
assign pressed  = (raw[15:8] != 8'hF0);
assign extended = pressed ? (raw[15:8] == 8'hE0) : (raw[23:16] == 8'hE0);

always_comb begin
	key_next = '{toggle: ~ps2_key.toggle, pressed: pressed, extended: extended,
		code: raw[7:0]};
	case (raw)
		`KBD_PRNSCR_DN: key_next[9:0] = `KBD_PRNSCR_DN_KEY;
		`KBD_PRNSCR_UP: key_next[9:0] = `KBD_PRNSCR_UP_KEY;
		`KBD_PAUSE_DN:  key_next[9:0] = `KBD_PAUSE_DN_KEY;
		default: ;
	endcase
end

always_ff @(posedge clk_sys or negedge rst_n) begin
	if (!rst_n) begin
		raw     <= '0;
		skip    <= 1'b0;
		ps2_key <= '0;
	end else if (kbd_start) begin
		raw  <= '0;
		skip <= 1'b0;
	end else if (kbd_end) begin
		if (!skip)
			ps2_key <= key_next;
		skip <= 1'b0;
	end else if (kbd_valid && !skip) begin
		// FF in the upper byte drops the rest of the frame
		if (&kbd_word[15:8])
			skip <= 1'b1;
		else
			raw <= {raw[23:0], kbd_word[7:0]};
	end
end

endmodule

//--- tb_hps_io.sv
`timescale 1ns/100ps
`include "hps_io_cfg.svh"

module tb_hps_io
	import hps_io_pkg::*;
();

localparam int N_KEYS = 16;
localparam int N_DATA = 16;

// host words and frames of all tests with 4 cycles per word, plus reset and status_set pulses
localparam int PLAN_WORDS     = 66 + 4 * N_KEYS + N_DATA;
localparam int PLAN_FRAMES    = 16 + N_KEYS;
localparam int TIMEOUT_CYCLES = 2 * (4 * PLAN_WORDS + 5 * PLAN_FRAMES + 20);

logic       clk_sys;
logic       rst_n;
logic       io_strobe;
logic       io_enable;
logic       fp_enable;
io_word_t   io_din;
io_word_t   io_dout;
status_t    status_in;
logic       status_set;
io_word_t   status_menumask;
logic [1:0] buttons;
logic       forced_scandoubler;
logic       direct_video;
status_t    status;
joy_t       joystick_0;
joy_t       joystick_1;
ps2_key_t   ps2_key;
logic       ioctl_download;
io_word_t   ioctl_index;
logic       ioctl_wr;
file_addr_t ioctl_addr;
logic [7:0] ioctl_dout;
file_ext_t  ioctl_file_ext;

// reference model state
logic [31:0] rng;
int          cycle_cnt = 0;
status_t     exp_status;
status_t     exp_req;
logic [3:0]  exp_stflg;
logic [10:0] exp_key;
file_addr_t  exp_addr;
logic [7:0]  exp_bytes[$];
logic [7:0]  wr_byte;
int          wr_cnt;

hps_io dut_i (
	.clk_sys            (clk_sys),
	.rst_n              (rst_n),
	.io_strobe          (io_strobe),
	.io_enable          (io_enable),
	.fp_enable          (fp_enable),
	.io_din             (io_din),
	.io_dout            (io_dout),
	.buttons            (buttons),
	.forced_scandoubler (forced_scandoubler),
	.direct_video       (direct_video),
	.status             (status),
	.status_in          (status_in),
	.status_set         (status_set),
	.status_menumask    (status_menumask),
	.joystick_0         (joystick_0),
	.joystick_1         (joystick_1),
	.ps2_key            (ps2_key),
	.ioctl_download     (ioctl_download),
	.ioctl_index        (ioctl_index),
	.ioctl_wr           (ioctl_wr),
	.ioctl_addr         (ioctl_addr),
	.ioctl_dout         (ioctl_dout),
	.ioctl_file_ext     (ioctl_file_ext)
);

initial begin
	clk_sys = 1'b0;
	forever #5 clk_sys = ~clk_sys;
end

always @(posedge clk_sys) begin
	cycle_cnt++;
	if (cycle_cnt >= TIMEOUT_CYCLES) begin
		$display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("Test failed");
		$fatal(1, "run stopped by the cycle limit");
	end
end

////////////////////////////////////////////////////////////////////////////
// helpers
////////////////////////////////////////////////////////////////////////////
function automatic logic [31:0] next_random();
	rng = rng ^ (rng << 13);
	rng = rng ^ (rng >> 17);
	rng = rng ^ (rng << 5);
	return rng;
endfunction

function automatic io_word_t random_word();
	logic [31:0] r;
	r = next_random();
	return r[15:0];
endfunction

task automatic check_equal(input string what, input logic [127:0] got,
	input logic [127:0] exp);
	if (got !== exp) begin
		$display("** Error at %0t: %s is %0h, expected %0h", $time, what, got, exp);
		$display("Test failed");
		$fatal(1, "stopped at the first mismatch");
	end
endtask

// inputs change 1 ns after the rising edge
task automatic next_cycle();
	@(posedge clk_sys);
	#1;
endtask

task automatic open_frame(input logic file_frame);
	next_cycle();
	io_enable = !file_frame;
	fp_enable = file_frame;
endtask

task automatic send_word(input io_word_t w);
	next_cycle();
	io_din    = w;
	io_strobe = 1'b1;
	next_cycle();
	io_strobe = 1'b0;
	next_cycle();
	next_cycle();
endtask

// enough cycles for kbd_end and the key update behind it
task automatic close_frame();
	next_cycle();
	io_enable = 1'b0;
	fp_enable = 1'b0;
	repeat (3) next_cycle();
endtask

// status_set stays high for several cycles and counts only once
task automatic pulse_status_set();
	status_t v;
	int      i;
	for (i = 0; i < 4; i++)
		v[32 * i +: 32] = next_random();
	next_cycle();
	status_in  = v;
	status_set = 1'b1;
	repeat (3) next_cycle();
	status_set = 1'b0;
	next_cycle();
	exp_stflg = exp_stflg + 1'b1;
	exp_req   = v;
endtask

// sends the low n_bytes of seq with the oldest byte first
task automatic send_key_frame(input logic [31:0] seq, input int n_bytes);
	logic [31:0] raw;
	logic [7:0]  upper;
	logic [7:0]  prev;
	io_word_t    r;
	int          i;
	raw = '0;
	open_frame(1'b0);
	send_word(`HPS_CMD_KBD);
	for (i = n_bytes - 1; i >= 0; i--) begin
		r     = random_word();
		upper = (r[15:8] == 8'hFF) ? 8'h00 : r[15:8];
		send_word({upper, seq[8 * i +: 8]});
		raw = {raw[23:0], seq[8 * i +: 8]};
	end
	close_frame();
	// F0 before the code means release, E0 marks an extended key
	prev         = raw[15:8];
	exp_key[10]  = ~exp_key[10];
	exp_key[9]   = (prev != 8'hF0);
	exp_key[8]   = (prev == 8'hF0) ? (raw[23:16] == 8'hE0) : (prev == 8'hE0);
	exp_key[7:0] = raw[7:0];
	if (raw == `KBD_PRNSCR_DN)
		exp_key[9:0] = `KBD_PRNSCR_DN_KEY;
	if (raw == `KBD_PRNSCR_UP)
		exp_key[9:0] = `KBD_PRNSCR_UP_KEY;
	if (raw == `KBD_PAUSE_DN)
		exp_key[9:0] = `KBD_PAUSE_DN_KEY;
	check_equal("ps2_key", ps2_key, exp_key);
endtask

// every write must match the next queued byte and address
always @(negedge clk_sys) begin
	if (rst_n && ioctl_wr) begin
		check_equal("ioctl_wr with a pending data word", exp_bytes.size() != 0, 1'b1);
		wr_byte = exp_bytes.pop_front();
		check_equal("ioctl_addr", ioctl_addr, exp_addr);
		check_equal("ioctl_dout", ioctl_dout, wr_byte);
		exp_addr = exp_addr + 1'b1;
		wr_cnt++;
	end
end

////////////////////////////////////////////////////////////////////////////
// test sequence
////////////////////////////////////////////////////////////////////////////
initial begin : main
	io_word_t    w;
	io_word_t    lo;
	io_word_t    hi;
	logic [31:0] r;
	int          i;

	rng             = 32'd11;
	rst_n           = 1'b0;
	io_strobe       = 1'b0;
	io_enable       = 1'b0;
	fp_enable       = 1'b0;
	io_din          = '0;
	status_in       = '0;
	status_set      = 1'b0;
	status_menumask = '0;
	exp_status      = '0;
	exp_req         = '0;
	exp_stflg       = '0;
	exp_key         = '0;
	exp_addr        = '0;
	wr_cnt          = 0;
	repeat (5) @(posedge clk_sys);
	#1;
	rst_n = 1'b1;
	check_equal("io_dout after reset", io_dout, 16'h0);
	check_equal("ioctl_download after reset", ioctl_download, 1'b0);

	// config word and joysticks
	w = random_word();
	open_frame(1'b0);
	send_word(`HPS_CMD_CFG);
	send_word(w);
	close_frame();
	check_equal("buttons", buttons, w[1:0]);
	check_equal("forced_scandoubler", forced_scandoubler, w[4]);
	check_equal("direct_video", direct_video, w[10]);
	lo = random_word();
	hi = random_word();
	open_frame(1'b0);
	send_word(`HPS_CMD_JOY0);
	send_word(lo);
	send_word(hi);
	close_frame();
	check_equal("joystick_0", joystick_0, {hi, lo});
	lo = random_word();
	hi = random_word();
	open_frame(1'b0);
	send_word(`HPS_CMD_JOY1);
	send_word(lo);
	send_word(hi);
	close_frame();
	check_equal("joystick_1", joystick_1, {hi, lo});

	// status words past 8 are ignored
	open_frame(1'b0);
	send_word(`HPS_CMD_STATUS);
	for (i = 1; i <= 10; i++) begin
		w = random_word();
		if (i <= 8)
			exp_status[16 * (i - 1) +: 16] = w;
		send_word(w);
	end
	close_frame();
	check_equal("status", status, exp_status);

	// status request read-back
	repeat (3) pulse_status_set();
	open_frame(1'b0);
	send_word(`HPS_CMD_STATUS_REQ);
	check_equal("status request head", io_dout, {8'h00, `HPS_STATUS_REQ_TAG, exp_stflg});
	for (i = 1; i <= 8; i++) begin
		send_word(random_word());
		check_equal("status request word", io_dout, exp_req[16 * (i - 1) +: 16]);
	end
	close_frame();
	check_equal("io_dout after frame", io_dout, 16'h0);
	status_menumask = random_word();
	open_frame(1'b0);
	send_word(`HPS_CMD_MENUMASK);
	send_word(random_word());
	check_equal("menu mask", io_dout, status_menumask);
	close_frame();

	// keyboard make, break and extended sequences
	for (i = 0; i < N_KEYS; i++) begin
		r = next_random();
		case (r[9:8])
			2'd0: send_key_frame({24'h0, r[7:0]}, 1);
			2'd1: send_key_frame({16'h0, 8'hF0, r[7:0]}, 2);
			2'd2: send_key_frame({16'h0, 8'hE0, r[7:0]}, 2);
			default: send_key_frame({8'h0, 8'hE0, 8'hF0, r[7:0]}, 3);
		endcase
	end
	send_key_frame(`KBD_PRNSCR_DN, 4);
	send_key_frame(`KBD_PRNSCR_UP, 4);
	send_key_frame(`KBD_PAUSE_DN, 4);
	// an FF upper byte drops the frame and the key stays as it was
	open_frame(1'b0);
	send_word(`HPS_CMD_KBD);
	send_word(16'h121C);
	send_word(16'hFF5A);
	send_word(16'h0033);
	close_frame();
	check_equal("ps2_key after skipped frame", ps2_key, exp_key);

	// file index and extension
	w = random_word();
	open_frame(1'b1);
	send_word(`FIO_FILE_INDEX);
	send_word(w);
	close_frame();
	check_equal("ioctl_index", ioctl_index, w);
	hi = random_word();
	lo = random_word();
	open_frame(1'b1);
	send_word(`FIO_FILE_INFO);
	send_word(hi);
	send_word(lo);
	close_frame();
	check_equal("ioctl_file_ext", ioctl_file_ext, {hi, lo});

	// download start at a random address
	w = random_word();
	if (w[7:0] == 8'h00 || w[7:0] == `FIO_UPLOAD_MARK)
		w[7:0] = 8'h01;
	lo = random_word();
	hi = random_word();
	open_frame(1'b1);
	send_word(`FIO_FILE_TX);
	send_word(w);
	send_word(lo);
	send_word(hi);
	close_frame();
	exp_addr = {hi[10:0], lo};
	check_equal("ioctl_download after start", ioctl_download, 1'b1);
	open_frame(1'b1);
	send_word(`FIO_FILE_TX_DAT);
	for (i = 0; i < N_DATA; i++) begin
		w = random_word();
		exp_bytes.push_back(w[7:0]);
		send_word(w);
	end
	close_frame();
	check_equal("write count", wr_cnt, N_DATA);

	// data words after a stop must not write
	w      = random_word();
	w[7:0] = 8'h00;
	open_frame(1'b1);
	send_word(`FIO_FILE_TX);
	send_word(w);
	close_frame();
	check_equal("ioctl_download after stop", ioctl_download, 1'b0);
	open_frame(1'b1);
	send_word(`FIO_FILE_TX_DAT);
	for (i = 0; i < 4; i++)
		send_word(random_word());
	close_frame();
	check_equal("write count after stop", wr_cnt, N_DATA);

	$display("Test passed");
	$finish;
end

endmodule

//--- uio_decoder.sv
`timescale 1ns/100ps
`include "hps_io_cfg.svh"

module uio_decoder
	import hps_io_pkg::*;
(
	input  logic       clk_sys,
	input  logic       rst_n,
	input  logic       io_strobe,
	input  logic       io_enable,
	input  io_word_t   io_din,
	output io_word_t   io_dout,
	input  status_t    status_in,
	input  logic       status_set,
	input  io_word_t   status_menumask,
	output logic [1:0] buttons,
	output logic       forced_scandoubler,
	output logic       direct_video,
	output status_t    status,
	output joy_t       joystick_0,
	output joy_t       joystick_1,
	output logic       kbd_start,
	output logic       kbd_valid,
	output logic       kbd_end,
	output io_word_t   kbd_word
);

io_word_t   cmd;
frame_cnt_t byte_cnt;
io_word_t   cfg;
logic       status_set_d;
logic [3:0] stflg;
status_t    status_req;
logic       data_stb;

assign data_stb = io_enable && io_strobe && (byte_cnt != '0);

// config word bits used by the core
assign buttons            = cfg[1:0];
assign forced_scandoubler = cfg[4];
assign direct_video       = cfg[10];

word_loader #(.payload_t(joy_t)) joy0_i (
	.clk_sys  (clk_sys),
	.rst_n    (rst_n),
	.load     (data_stb && (cmd == `HPS_CMD_JOY0)),
	.word_idx (byte_cnt),
	.word     (io_din),
	.value    (joystick_0)
);

word_loader #(.payload_t(joy_t)) joy1_i (
	.clk_sys  (clk_sys),
	.rst_n    (rst_n),
	.load     (data_stb && (cmd == `HPS_CMD_JOY1)),
	.word_idx (byte_cnt),
	.word     (io_din),
	.value    (joystick_1)
);

word_loader #(.payload_t(status_t)) status_i (
	.clk_sys  (clk_sys),
	.rst_n    (rst_n),
	.load     (data_stb && (cmd == `HPS_CMD_STATUS)),
	.word_idx (byte_cnt),
	.word     (io_din),
	.value    (status)
);

// status change request from the core, counted on each rising edge
always_ff @(posedge clk_sys or negedge rst_n) begin
	if (!rst_n) begin
		status_set_d <= 1'b0;
		stflg        <= '0;
		status_req   <= '0;
	end else begin
		status_set_d <= status_set;
		if (status_set && !status_set_d) begin
			stflg      <= stflg + 1'b1;
			status_req <= status_in;
		end
	end
end

////////////////////////////////////////////////////////////////////////////
// frame decoding and read-back
////////////////////////////////////////////////////////////////////////////
always_ff @(posedge clk_sys or negedge rst_n) begin
	if (!rst_n) begin
		cmd       <= '0;
		byte_cnt  <= '0;
		io_dout   <= '0;
		cfg       <= '0;
		kbd_start <= 1'b0;
		kbd_valid <= 1'b0;
		kbd_end   <= 1'b0;
		kbd_word  <= '0;
	end else begin
		kbd_start <= 1'b0;
		kbd_valid <= 1'b0;
		kbd_end   <= 1'b0;
		if (!io_enable) begin
			// cmd clears here, so kbd_end lasts one cycle
			kbd_end  <= (cmd == `HPS_CMD_KBD);
			cmd      <= '0;
			byte_cnt <= '0;
			io_dout  <= '0;
		end else if (io_strobe) begin
			io_dout <= '0;
			if (!(&byte_cnt))
				byte_cnt <= byte_cnt + 1'b1;
			if (byte_cnt == '0) begin
				cmd       <= io_din;
				kbd_start <= (io_din == `HPS_CMD_KBD);
				if (io_din == `HPS_CMD_STATUS_REQ)
					io_dout <= {8'h00, `HPS_STATUS_REQ_TAG, stflg};
			end else begin
				case (cmd)
					`HPS_CMD_CFG: cfg <= io_din;
					`HPS_CMD_KBD: begin
						kbd_valid <= 1'b1;
						kbd_word  <= io_din;
					end
					`HPS_CMD_STATUS_REQ: begin
						if (byte_cnt <= frame_cnt_t'(`HPS_STATUS_WORDS))
							io_dout <= status_req[(int'(byte_cnt) - 1) * 16 +: 16];
					end
					`HPS_CMD_MENUMASK: begin
						if (byte_cnt == frame_cnt_t'(1))
							io_dout <= status_menumask;
					end
					default: ;
				endcase
			end
		end
	end
end

endmodule

//--- word_loader.sv
`timescale 1ns/100ps

module word_loader
	import hps_io_pkg::*;
#(
	parameter type payload_t = io_word_t
) (
	input  logic       clk_sys,
	input  logic       rst_n,
	input  logic       load,
	input  frame_cnt_t word_idx,
	input  io_word_t   word,
	output payload_t   value
);

localparam int WORD_W  = $bits(io_word_t);
localparam int N_WORDS = $bits(payload_t) / WORD_W;

// word 1 lands in the lowest slice, indexes past the payload are dropped
always_ff @(posedge clk_sys or negedge rst_n) begin
	if (!rst_n) begin
		value <= '0;
	end else if (load && (word_idx != '0) && (int'(word_idx) <= N_WORDS)) begin
		value[(int'(word_idx) - 1) * WORD_W +: WORD_W] <= word;
	end
end

// word 0 is the command and never reaches a payload
assert property (@(posedge clk_sys) disable iff (!rst_n) load |-> (word_idx != '0))
	else $error("word_loader: load with word index 0");

endmodule
